/* design/rendererPkg.sv */
package rendererPkg;

	typedef logic [9:0] pixelCoord_t;
	typedef logic [4:0] tileColumn_t;
	typedef logic [3:0] tileRow_t;
	typedef logic [3:0] tileOffset_t;
	typedef logic [2:0] colorCode_t;
	typedef logic [47:0] spriteRow_t;
	typedef logic [23:0] rgb_t;

	// Map window placement on the scan
	localparam pixelCoord_t MapTop = 10'd235;
	localparam pixelCoord_t MapLeft = 10'd332;
	localparam int MapRows = 10;
	localparam int MapColumns = 20;
	localparam int TileSize = 16;

	// Code 0 is transparent
	localparam colorCode_t CodeBlue = 3'd1;
	localparam colorCode_t CodeWhite = 3'd2;
	localparam colorCode_t CodeCyan = 3'd3;
	localparam colorCode_t CodeOrange = 3'd4;
	localparam colorCode_t CodeBlack = 3'd5;
	localparam colorCode_t CodeGreen = 3'd6;
	localparam colorCode_t CodeRed = 3'd7;

	localparam rgb_t ColorBlue = 24'h0000FF;
	localparam rgb_t ColorWhite = 24'hFFFFFF;
	localparam rgb_t ColorCyan = 24'h00FFFF;
	localparam rgb_t ColorOrange = 24'hFFA500;
	localparam rgb_t ColorBlack = 24'h000000;
	localparam rgb_t ColorGreen = 24'h00FF00;
	localparam rgb_t ColorRed = 24'hFF0000;

	// Background codes in the tile map
	localparam logic [2:0] TileWall = 3'd5;
	localparam logic [2:0] TilePipe = 3'd6;

	// First row of each sprite in the bitmap ROM
	localparam int SpriteRobot = 0;
	localparam int SpriteCursor = 16;
	localparam int SpriteTrash = 32;
	localparam int SpriteWall = 48;
	localparam int SpritePipe = 64;
	localparam int SpriteBlackCell = 80;
	localparam int SpriteDepth = 96;

endpackage

/* design/tileCoordIf.sv */
`timescale 1ns/1ps

interface tileCoordIf;

	logic active;
	rendererPkg::tileRow_t tileRow;
	rendererPkg::tileColumn_t tileColumn;
	rendererPkg::tileOffset_t rowOffset;
	rendererPkg::tileOffset_t columnOffset;

	modport locator (
		output active, tileRow, tileColumn, rowOffset, columnOffset
	);

	modport compositor (
		input active, tileRow, tileColumn, rowOffset, columnOffset
	);

endinterface

/* design/tileLocator.sv */
`timescale 1ns/1ps

module tileLocator (
	input logic Clock25,
	input logic arstN,
	input rendererPkg::pixelCoord_t pixelRow,
	input rendererPkg::pixelCoord_t pixelColumn,
	tileCoordIf.locator coord
);

	rendererPkg::pixelCoord_t rowDelta;
	rendererPkg::pixelCoord_t columnDelta;
	logic inWindow;

	// Coordinates above or left of the origin wrap to large values
	assign rowDelta = pixelRow - rendererPkg::MapTop;
	assign columnDelta = pixelColumn - rendererPkg::MapLeft;

	assign inWindow = (rowDelta < 10'(rendererPkg::MapRows * rendererPkg::TileSize))
		&& (columnDelta < 10'(rendererPkg::MapColumns * rendererPkg::TileSize));

	always_ff @(posedge Clock25 or negedge arstN)
	begin
		if (!arstN)
		begin
			coord.active <= 1'b0;
			coord.tileRow <= '0;
			coord.tileColumn <= '0;
			coord.rowOffset <= '0;
			coord.columnOffset <= '0;
		end
		else if (inWindow)
		begin
			coord.active <= 1'b1;
			coord.tileRow <= rendererPkg::tileRow_t'(rowDelta >> $clog2(rendererPkg::TileSize));
			coord.tileColumn <=
				rendererPkg::tileColumn_t'(columnDelta >> $clog2(rendererPkg::TileSize));
			coord.rowOffset <= rendererPkg::tileOffset_t'(rowDelta);
			coord.columnOffset <= rendererPkg::tileOffset_t'(columnDelta);
		end
		else
		begin
			coord.active <= 1'b0;
			coord.tileRow <= '0;
			coord.tileColumn <= '0;
			coord.rowOffset <= '0;
			coord.columnOffset <= '0;
		end
	end

endmodule

/* design/layerCompositor.sv */
`timescale 1ns/1ps

module layerCompositor (
	input logic Clock25,
	input logic arstN,
	tileCoordIf.compositor coord,
	input rendererPkg::tileColumn_t blackCellColumn,
	input rendererPkg::tileColumn_t trashColumn,
	input rendererPkg::tileColumn_t robotColumn,
	input rendererPkg::tileColumn_t cursorColumn,
	input rendererPkg::tileRow_t blackCellRow,
	input rendererPkg::tileRow_t trashRow,
	input rendererPkg::tileRow_t robotRow,
	input rendererPkg::tileRow_t cursorRow,
	output rendererPkg::colorCode_t pixelCode,
	output logic pixelActive
);

	rendererPkg::spriteRow_t spriteRom [0:rendererPkg::SpriteDepth-1];
	logic [rendererPkg::MapColumns*3-1:0] tileMap [0:rendererPkg::MapRows-1];

	logic [rendererPkg::MapColumns*3-1:0] mapRow;
	logic [2:0] tileCode;
	int backgroundBase;
	rendererPkg::colorCode_t backgroundCode;
	rendererPkg::colorCode_t blackCellCode;
	rendererPkg::colorCode_t trashCode;
	rendererPkg::colorCode_t robotCode;
	rendererPkg::colorCode_t cursorCode;
	rendererPkg::colorCode_t mergedCode;

	initial
	begin
		$readmemh("design/spriteRom.mem", spriteRom);
		$readmemh("design/tileMap.mem", tileMap);
	end

	// Leftmost pixel sits in the top field of the row
	function automatic rendererPkg::colorCode_t spriteField(input int base);
		rendererPkg::spriteRow_t row;
		row = spriteRom[base + coord.rowOffset];
		return row[(rendererPkg::TileSize - 1 - coord.columnOffset) * 3 +: 3];
	endfunction

	function automatic rendererPkg::colorCode_t overlayField(
		input rendererPkg::tileColumn_t column,
		input rendererPkg::tileRow_t row,
		input int base
	);
		if (column == coord.tileColumn && row == coord.tileRow)
			return spriteField(base);
		return '0;
	endfunction

	// Leftmost map column in the top field
	assign mapRow = tileMap[coord.tileRow];
	assign tileCode = mapRow[(rendererPkg::MapColumns - 1 - coord.tileColumn) * 3 +: 3];

	always_comb
	begin
		case (tileCode)
			rendererPkg::TileWall: backgroundBase = rendererPkg::SpriteWall;
			rendererPkg::TilePipe: backgroundBase = rendererPkg::SpritePipe;
			default: backgroundBase = rendererPkg::SpriteWall;
		endcase
	end

	assign backgroundCode = spriteField(backgroundBase);
	assign blackCellCode = overlayField(blackCellColumn, blackCellRow, rendererPkg::SpriteBlackCell);
	assign trashCode = overlayField(trashColumn, trashRow, rendererPkg::SpriteTrash);
	assign robotCode = overlayField(robotColumn, robotRow, rendererPkg::SpriteRobot);
	assign cursorCode = overlayField(cursorColumn, cursorRow, rendererPkg::SpriteCursor);

	// Later layers win wherever they are opaque
	always_comb
	begin
		mergedCode = backgroundCode;
		if (blackCellCode != '0)
			mergedCode = blackCellCode;
		if (trashCode != '0)
			mergedCode = trashCode;
		if (robotCode != '0)
			mergedCode = robotCode;
		if (cursorCode != '0)
			mergedCode = cursorCode;
	end

	always_ff @(posedge Clock25 or negedge arstN)
	begin
		if (!arstN)
		begin
			pixelCode <= '0;
			pixelActive <= 1'b0;
		end
		else
		begin
			pixelCode <= mergedCode;
			pixelActive <= coord.active;
		end
	end

endmodule

/* design/paletteEncoder.sv */
`timescale 1ns/1ps

module paletteEncoder (
	input logic Clock25,
	input logic arstN,
	input rendererPkg::colorCode_t pixelCode,
	input logic pixelActive,
	output rendererPkg::rgb_t rgb
);

	rendererPkg::rgb_t paletteColor;

	always_comb
	begin
		case (pixelCode)
			rendererPkg::CodeBlue: paletteColor = rendererPkg::ColorBlue;
			rendererPkg::CodeWhite: paletteColor = rendererPkg::ColorWhite;
			rendererPkg::CodeCyan: paletteColor = rendererPkg::ColorCyan;
			rendererPkg::CodeOrange: paletteColor = rendererPkg::ColorOrange;
			rendererPkg::CodeBlack: paletteColor = rendererPkg::ColorBlack;
			rendererPkg::CodeGreen: paletteColor = rendererPkg::ColorGreen;
			rendererPkg::CodeRed: paletteColor = rendererPkg::ColorRed;
			default: paletteColor = rendererPkg::ColorBlack;
		endcase
	end

	// Blank outside the map window
	always_ff @(posedge Clock25 or negedge arstN)
	begin
		if (!arstN)
			rgb <= rendererPkg::ColorBlack;
		else
			rgb <= pixelActive ? paletteColor : rendererPkg::ColorBlack;
	end

endmodule

/* design/tileRenderer.sv */
`timescale 1ns/1ps

module tileRenderer (
	input logic Clock25,
	input logic arstN,
	input rendererPkg::pixelCoord_t pixelRow,
	input rendererPkg::pixelCoord_t pixelColumn,
	input rendererPkg::tileColumn_t blackCellColumn,
	input rendererPkg::tileColumn_t trashColumn,
	input rendererPkg::tileColumn_t robotColumn,
	input rendererPkg::tileColumn_t cursorColumn,
	input rendererPkg::tileRow_t blackCellRow,
	input rendererPkg::tileRow_t trashRow,
	input rendererPkg::tileRow_t robotRow,
	input rendererPkg::tileRow_t cursorRow,
	output rendererPkg::rgb_t rgb
);

	tileCoordIf coordLink ();

	rendererPkg::colorCode_t pixelCode;
	logic pixelActive;

	// Stage 1, scan position to tile position
	tileLocator tileLocator_inst (
		.Clock25(Clock25),
		.arstN(arstN),
		.pixelRow(pixelRow),
		.pixelColumn(pixelColumn),
		.coord(coordLink.locator)
	);

	// Stage 2, background and overlays
	layerCompositor layerCompositor_inst (
		.Clock25(Clock25),
		.arstN(arstN),
		.coord(coordLink.compositor),
		.blackCellColumn(blackCellColumn),
		.trashColumn(trashColumn),
		.robotColumn(robotColumn),
		.cursorColumn(cursorColumn),
		.blackCellRow(blackCellRow),
		.trashRow(trashRow),
		.robotRow(robotRow),
		.cursorRow(cursorRow),
		.pixelCode(pixelCode),
		.pixelActive(pixelActive)
	);

	// Stage 3, code to RGB
	paletteEncoder paletteEncoder_inst (
		.Clock25(Clock25),
		.arstN(arstN),
		.pixelCode(pixelCode),
		.pixelActive(pixelActive),
		.rgb(rgb)
	);

endmodule

/* verification/tileRenderer_sva.sv */
`timescale 1ns/1ps

module tileRenderer_sva (
	input logic Clock25,
	input logic arstN,
	input rendererPkg::pixelCoord_t pixelRow,
	input rendererPkg::pixelCoord_t pixelColumn,
	input rendererPkg::rgb_t rgb
);

	logic outsideWindow;
	int failCount = 0;

	assign outsideWindow = (pixelRow < 10'd235) || (pixelRow > 10'd394)
		|| (pixelColumn < 10'd332) || (pixelColumn > 10'd651);

	blackInReset: assert property (@(posedge Clock25) !arstN |-> rgb == 24'h000000)
		else
		begin
			failCount++;
			$error("rgb not black during reset");
		end

	knownPalette: assert property (@(posedge Clock25) rgb inside {24'h0000FF, 24'hFFFFFF,
		24'h00FFFF, 24'hFFA500, 24'h000000, 24'h00FF00, 24'hFF0000})
		else
		begin
			failCount++;
			$error("rgb outside the palette");
		end

	blankOutside: assert property (@(posedge Clock25) disable iff (!arstN)
		outsideWindow |-> ##3 rgb == 24'h000000)
		else
		begin
			failCount++;
			$error("pixel outside the window not blanked");
		end

endmodule

bind tileRenderer tileRenderer_sva tileRenderer_sva_inst (.*);

/* verification/tileRendererTb.sv */
`timescale 1ns/1ps

module tileRendererTb;

	localparam int TimeoutCycles = 6000;

	logic Clock25;
	logic arstN;
	rendererPkg::pixelCoord_t pixelRow;
	rendererPkg::pixelCoord_t pixelColumn;
	rendererPkg::tileColumn_t blackCellColumn;
	rendererPkg::tileColumn_t trashColumn;
	rendererPkg::tileColumn_t robotColumn;
	rendererPkg::tileColumn_t cursorColumn;
	rendererPkg::tileRow_t blackCellRow;
	rendererPkg::tileRow_t trashRow;
	rendererPkg::tileRow_t robotRow;
	rendererPkg::tileRow_t cursorRow;
	rendererPkg::rgb_t rgb;

	rendererPkg::spriteRow_t romModel [0:rendererPkg::SpriteDepth-1];
	logic [59:0] mapModel [0:9];
	rendererPkg::rgb_t expectQueue [$];
	rendererPkg::pixelCoord_t prevRow;
	rendererPkg::pixelCoord_t prevColumn;
	logic prevValid;
	integer seed;
	int cycleCount;

	tileRenderer tileRenderer_inst (.*);

	always #20 Clock25 = ~Clock25;

	function automatic rendererPkg::rgb_t paletteOf(input rendererPkg::colorCode_t code);
		case (code)
			3'd1: return rendererPkg::ColorBlue;
			3'd2: return rendererPkg::ColorWhite;
			3'd3: return rendererPkg::ColorCyan;
			3'd4: return rendererPkg::ColorOrange;
			3'd6: return rendererPkg::ColorGreen;
			3'd7: return rendererPkg::ColorRed;
			default: return rendererPkg::ColorBlack;
		endcase
	endfunction

	function automatic rendererPkg::colorCode_t fieldOf(input int base, input int ro, input int co);
		rendererPkg::spriteRow_t bits;
		bits = romModel[base + ro];
		return bits[(15 - co) * 3 +: 3];
	endfunction

	// Reference pixel from scan position and current placements
	function automatic rendererPkg::rgb_t modelRgb(input rendererPkg::pixelCoord_t row,
		input rendererPkg::pixelCoord_t column);
		rendererPkg::pixelCoord_t dr;
		rendererPkg::pixelCoord_t dc;
		int tr;
		int tc;
		int ro;
		int co;
		logic [59:0] mapBits;
		rendererPkg::colorCode_t code;
		rendererPkg::colorCode_t layer;
		dr = row - rendererPkg::MapTop;
		dc = column - rendererPkg::MapLeft;
		if (dr >= 10'd160 || dc >= 10'd320)
			return rendererPkg::ColorBlack;
		tr = dr / 16;
		tc = dc / 16;
		ro = dr % 16;
		co = dc % 16;
		mapBits = mapModel[tr];
		if (mapBits[(19 - tc) * 3 +: 3] == rendererPkg::TilePipe)
			code = fieldOf(rendererPkg::SpritePipe, ro, co);
		else
			code = fieldOf(rendererPkg::SpriteWall, ro, co);
		layer = (blackCellRow == tr && blackCellColumn == tc) ?
			fieldOf(rendererPkg::SpriteBlackCell, ro, co) : 3'd0;
		if (layer != 3'd0)
			code = layer;
		layer = (trashRow == tr && trashColumn == tc) ? fieldOf(rendererPkg::SpriteTrash, ro, co) : 3'd0;
		if (layer != 3'd0)
			code = layer;
		layer = (robotRow == tr && robotColumn == tc) ? fieldOf(rendererPkg::SpriteRobot, ro, co) : 3'd0;
		if (layer != 3'd0)
			code = layer;
		layer = (cursorRow == tr && cursorColumn == tc) ?
			fieldOf(rendererPkg::SpriteCursor, ro, co) : 3'd0;
		if (layer != 3'd0)
			code = layer;
		return paletteOf(code);
	endfunction

	task automatic checkRgb(input rendererPkg::rgb_t expected, input rendererPkg::rgb_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t: rgb expected %h, got %h", $time, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "rgb mismatch");
		end
	endtask

	task automatic drivePixel(input int row, input int column);
		@(posedge Clock25);
		pixelRow <= rendererPkg::pixelCoord_t'(row);
		pixelColumn <= rendererPkg::pixelCoord_t'(column);
	endtask

	// Called right after a rising edge
	task automatic placeSprites(input int bcRow, input int bcCol, input int trRow, input int trCol,
		input int rbRow, input int rbCol, input int cuRow, input int cuCol);
		blackCellRow <= rendererPkg::tileRow_t'(bcRow);
		blackCellColumn <= rendererPkg::tileColumn_t'(bcCol);
		trashRow <= rendererPkg::tileRow_t'(trRow);
		trashColumn <= rendererPkg::tileColumn_t'(trCol);
		robotRow <= rendererPkg::tileRow_t'(rbRow);
		robotColumn <= rendererPkg::tileColumn_t'(rbCol);
		cursorRow <= rendererPkg::tileRow_t'(cuRow);
		cursorColumn <= rendererPkg::tileColumn_t'(cuCol);
	endtask

	task automatic scanTile(input int tr, input int tc, input int rowStep);
		for (int ro = 0; ro < 16; ro += rowStep)
			for (int co = 0; co < 16; co++)
				drivePixel(235 + tr * 16 + ro, 332 + tc * 16 + co);
	endtask

	task automatic driveOutside(input int count);
		int row;
		int column;
		for (int i = 0; i < count; i++)
		begin
			do
			begin
				row = {$random(seed)} % 1024;
				column = {$random(seed)} % 1024;
			end
			while (row >= 235 && row <= 394 && column >= 332 && column <= 651);
			drivePixel(row, column);
		end
	endtask

	task automatic streamRandom(input int count);
		for (int i = 0; i < count; i++)
		begin
			if ({$random(seed)} % 4 == 0)
				drivePixel({$random(seed)} % 1024, {$random(seed)} % 1024);
			else
				drivePixel(235 + {$random(seed)} % 160, 332 + {$random(seed)} % 320);
			if (i % 64 == 0)
				placeSprites({$random(seed)} % 11, {$random(seed)} % 20, {$random(seed)} % 11,
					{$random(seed)} % 20, {$random(seed)} % 11, {$random(seed)} % 20,
					{$random(seed)} % 11, {$random(seed)} % 20);
		end
	endtask

	// Model runs one edge behind the locator, check two edges later
	always @(posedge Clock25)
	begin
		rendererPkg::rgb_t expected;
		if (!arstN)
		begin
			expectQueue.delete();
			prevValid = 1'b0;
			checkRgb(rendererPkg::ColorBlack, rgb);
		end
		else
		begin
			expected = prevValid ? modelRgb(prevRow, prevColumn) : rendererPkg::ColorBlack;
			expectQueue.push_back(expected);
			if (expectQueue.size() > 2)
				checkRgb(expectQueue.pop_front(), rgb);
			else
				checkRgb(rendererPkg::ColorBlack, rgb);
			prevRow = pixelRow;
			prevColumn = pixelColumn;
			prevValid = 1'b1;
		end
	end

	always @(posedge Clock25)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		seed = 32'hee1c_ea9f;
		cycleCount = 0;
		prevValid = 1'b0;
		Clock25 = 1'b0;
		arstN = 1'b1;
		pixelRow = '0;
		pixelColumn = '0;
		blackCellRow = 4'd15;
		trashRow = 4'd15;
		robotRow = 4'd15;
		cursorRow = 4'd15;
		blackCellColumn = '0;
		trashColumn = '0;
		robotColumn = '0;
		cursorColumn = '0;
		$readmemh("design/spriteRom.mem", romModel);
		$readmemh("design/tileMap.mem", mapModel);

		// Falling reset edge just after time zero
		#1 arstN = 1'b0;
		repeat (3) @(posedge Clock25);
		arstN <= 1'b1;

		// Window edges and random blanking
		drivePixel(234, 400);
		drivePixel(395, 400);
		drivePixel(300, 331);
		drivePixel(300, 652);
		drivePixel(235, 332);
		drivePixel(394, 651);
		driveOutside(100);

		// Background only, one pixel row per tile row
		for (int tr = 0; tr < 10; tr++)
			for (int column = 332; column < 652; column += 7)
				drivePixel(235 + tr * 16 + (tr * 5) % 16, column);

		// Each overlay alone on a pipe tile
		for (int k = 0; k < 4; k++)
		begin
			drivePixel(235 + 32, 332 + 80);
			placeSprites(k == 0 ? 2 : 15, 5, k == 1 ? 2 : 15, 5, k == 2 ? 2 : 15, 5,
				k == 3 ? 2 : 15, 5);
			scanTile(2, 5, 2);
		end

		// All overlays stacked
		drivePixel(235 + 32, 332 + 80);
		placeSprites(2, 5, 2, 5, 2, 5, 2, 5);
		scanTile(2, 5, 1);

		streamRandom(4000);
		repeat (5) @(posedge Clock25);

		if (tileRenderer_inst.tileRenderer_sva_inst.failCount == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "assertions failed");
		end
	end

endmodule

/* sim.f */
design/rendererPkg.sv
design/tileCoordIf.sv
design/tileLocator.sv
design/layerCompositor.sv
design/paletteEncoder.sv
design/tileRenderer.sv
verification/tileRenderer_sva.sv
verification/tileRendererTb.sv

/* design/spriteRom.mem */
// One bitmap row per line, 16 pixels of 3 bits, leftmost pixel in the top bits
000492492000
000FFFFFF000
000492492000
249492492249
249492492249
492492492492
492FFFFFF492
492492492492
492492492492
492249249492
492249249492
249492492249
000492492000
000492492000
000249249000
000000000000
DB6DB6DB6DB6
DB6DB6DB6DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6000000DB6
DB6DB6DB6DB6
DB6DB6DB6DB6
000000000000
000000000000
000000000000
000000000000
000924924000
000924924000
000924924000
000924924000
000924924000
000924924000
000924924000
000924924000
000000000000
000000000000
000000000000
000000000000
492492492492
924924924492
924924924492
924924924492
924924924492
924924924492
924924924492
924924924492
492492492492
924492924924
924492924924
924492924924
924492924924
924492924924
924492924924
924492924924
249249249249
249249249249
249249249249
249249249249
6DB6DB6DB6DB
6DB6DB6DB6DB
6DB0000006DB
6DB0000006DB
6DB0000006DB
6DB0000006DB
6DB6DB6DB6DB
6DB6DB6DB6DB
249249249249
249249249249
249249249249
249249249249
000000000000
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D
B6DB6DB6DB6D

/* design/tileMap.mem */
// One map row per line, 20 tile codes of 3 bits, leftmost tile in the top bits
B6DB6DB6DB6DB6D
BB6DB6B76DB6DB5
BB6DB6DB6DADDB5
BB6B76DB6DB6DB5
BB6DB6DB6B76DB5
BB6DADDB6DB6DB5
BB6DB6B76DADDB5
BB6B76DB6DB6DB5
BB6DB6DADDB6DB5
B6DB6DB6DB6DB6D
